/* hdl/jtag_debug_settings.svh */
`ifndef JTAG_DEBUG_SETTINGS_SVH
`define JTAG_DEBUG_SETTINGS_SVH

// Instruction register length
`define JTAG_IR_WIDTH 4

// Register map geometry
`define DBG_ADDR_WIDTH 8
`define DBG_DATA_WIDTH 32

// Device ID, bit 0 fixed to 1 per 1149.1
`define JTAG_IDCODE 32'h1A5C_0E93

// Flops per pin in the clk domain
`define JTAG_SYNC_STAGES 2

`endif

/* hdl/jtag_debug_pkg.sv */
`include "jtag_debug_settings.svh"

package jtag_debug_pkg;

	// IEEE 1149.1 TAP states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR_SCAN,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR_SCAN,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} jtag_state_e;

	// Unlisted codes fall back to BYPASS
	typedef enum logic [`JTAG_IR_WIDTH-1:0] {
		INSTR_IDCODE   = 4'd1,
		INSTR_REG_ADDR = 4'd8,
		INSTR_REG_DATA = 4'd9,
		INSTR_BYPASS   = 4'd15
	} jtag_instr_e;

	typedef enum logic [`DBG_ADDR_WIDTH-1:0] {
		ADDR_CTRL       = 8'h00,
		ADDR_CDR_GAIN   = 8'h01,
		ADDR_PI_CTL     = 8'h02,
		ADDR_PRBS_CFG   = 8'h03,
		ADDR_PHASE_EST  = 8'h10,
		ADDR_PRBS_ERR   = 8'h11,
		ADDR_PRBS_TOTAL = 8'h12
	} dbg_reg_addr_e;

endpackage

/* hdl/jtag_pin_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_debug_settings.svh"

module jtag_pin_sync (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_o
);
	localparam int TCK_BIT = 0;
	localparam int TMS_BIT = 1;
	localparam int TDI_BIT = 2;
	localparam int TRST_BIT = 3;

	// Idle pin levels: TRST_N released, the rest low
	localparam logic [3:0] PIN_IDLE = 4'b1000;

	logic [3:0] pins;
	logic [`JTAG_SYNC_STAGES:0][3:0] pipe;
	logic tck_s;
	logic tck_prev;

	assign pins = {trst_n_i, tdi_i, tms_i, tck_i};

	// All four pins share one chain; the extra last stage is the edge reference
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pipe <= {(`JTAG_SYNC_STAGES+1){PIN_IDLE}};
		end else begin
			pipe <= {pipe[`JTAG_SYNC_STAGES-1:0], pins};
		end
	end

	assign tck_s = pipe[`JTAG_SYNC_STAGES-1][TCK_BIT];
	assign tck_prev = pipe[`JTAG_SYNC_STAGES][TCK_BIT];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			tck_rise_o <= tck_s & ~tck_prev;
			tck_fall_o <= ~tck_s & tck_prev;
		end
	end

	// Taken from the last stage so they line up with the edge pulses
	assign tms_o = pipe[`JTAG_SYNC_STAGES][TMS_BIT];
	assign tdi_o = pipe[`JTAG_SYNC_STAGES][TDI_BIT];
	assign trst_o = ~pipe[`JTAG_SYNC_STAGES][TRST_BIT];

endmodule

`default_nettype wire

/* hdl/jtag_tap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_debug_settings.svh"

module jtag_tap_ctrl (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_rise_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_i,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o,
	output jtag_debug_pkg::jtag_instr_e instr_o,
	output logic ir_tdo_o,
	output logic ir_shift_o
);
	import jtag_debug_pkg::*;

	jtag_state_e state_q;
	jtag_state_e state_d;
	logic [`JTAG_IR_WIDTH-1:0] ir_sr;

	always_comb begin
		case (state_q)
			TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR:       state_d = tms_i ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_d = tms_i ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_d = tms_i ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_d = tms_i ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_d = tms_i ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_d = tms_i ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_d = tms_i ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_d = tms_i ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_d = tms_i ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_d = tms_i ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			default:          state_d = TEST_LOGIC_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i || trst_i) begin
			state_q <= TEST_LOGIC_RESET;
		end else if (tck_rise_i) begin
			state_q <= state_d;
		end
	end

	// DR actions on the TCK rise; update fires on the edge that enters Update-DR
	assign capture_dr_o = tck_rise_i && (state_q == CAPTURE_DR);
	assign shift_dr_o = tck_rise_i && (state_q == SHIFT_DR);
	assign update_dr_o = tck_rise_i && (state_d == UPDATE_DR);

	// Instruction shift path with LSB out first
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state_q == CAPTURE_IR) begin
				ir_sr <= 4'b0001;
			end else if (state_q == SHIFT_IR) begin
				ir_sr <= {tdi_i, ir_sr[`JTAG_IR_WIDTH-1:1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i || trst_i) begin
			instr_o <= INSTR_IDCODE;
		end else if (tck_rise_i) begin
			if (state_d == TEST_LOGIC_RESET) begin
				instr_o <= INSTR_IDCODE;
			end else if (state_d == UPDATE_IR) begin
				instr_o <= jtag_instr_e'(ir_sr);
			end
		end
	end

	assign ir_tdo_o = ir_sr[0];
	assign ir_shift_o = (state_q == SHIFT_IR);

endmodule

`default_nettype wire

/* hdl/jtag_dr_chain.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_debug_settings.svh"

module jtag_dr_chain (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_rise_i,
	input wire logic tck_fall_i,
	input wire logic tdi_i,
	input wire logic capture_dr_i,
	input wire logic shift_dr_i,
	input wire logic update_dr_i,
	input wire jtag_debug_pkg::jtag_instr_e instr_i,
	input wire logic ir_tdo_i,
	input wire logic ir_shift_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] rd_data_i,
	output logic [`DBG_ADDR_WIDTH-1:0] reg_addr_o,
	output logic rd_req_o,
	output logic wr_en_o,
	output logic [`DBG_DATA_WIDTH-1:0] wr_data_o,
	output logic tdo_o
);
	import jtag_debug_pkg::*;

	localparam int DW = `DBG_DATA_WIDTH;
	localparam int AW = `DBG_ADDR_WIDTH;

	// Shared shift register whose active length follows the instruction
	logic [DW-1:0] dr_sr;
	logic rd_pending;

	assign rd_req_o = capture_dr_i && (instr_i == INSTR_REG_DATA);
	assign wr_en_o = update_dr_i && (instr_i == INSTR_REG_DATA);
	assign wr_data_o = dr_sr;

	// Readback arrives one cycle after the request
	always_ff @(posedge clk) begin
		if (reset_i) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= rd_req_o;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_pending) begin
			dr_sr <= rd_data_i;
		end else if (capture_dr_i) begin
			case (instr_i)
				INSTR_IDCODE:   dr_sr <= `JTAG_IDCODE;
				INSTR_REG_ADDR: dr_sr <= {{(DW-AW){1'b0}}, reg_addr_o};
				INSTR_REG_DATA: dr_sr <= '0;
				default:        dr_sr[0] <= 1'b0;
			endcase
		end else if (shift_dr_i && tck_rise_i) begin
			case (instr_i)
				INSTR_IDCODE,
				INSTR_REG_DATA: dr_sr <= {tdi_i, dr_sr[DW-1:1]};
				INSTR_REG_ADDR: dr_sr[AW-1:0] <= {tdi_i, dr_sr[AW-1:1]};
				default:        dr_sr[0] <= tdi_i;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			reg_addr_o <= '0;
		end else if (update_dr_i && instr_i == INSTR_REG_ADDR) begin
			reg_addr_o <= dr_sr[AW-1:0];
		end
	end

	// TDO launched on the falling edge
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			tdo_o <= ir_shift_i ? ir_tdo_i : dr_sr[0];
		end
	end

endmodule

`default_nettype wire

/* hdl/debug_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_debug_settings.svh"

module debug_reg_file (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic [`DBG_ADDR_WIDTH-1:0] reg_addr_i,
	input wire logic rd_req_i,
	input wire logic wr_en_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] wr_data_i,
	output logic [`DBG_DATA_WIDTH-1:0] rd_data_o,
	input wire logic [9:0] phase_est_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] prbs_err_bits_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] prbs_total_bits_i,
	output logic [3:0] kp_o,
	output logic [3:0] ki_o,
	output logic en_ext_pi_ctl_o,
	output logic [7:0] ext_pi_ctl_o,
	output logic [1:0] prbs_eqn_o,
	output logic prbs_cke_o,
	output logic cdr_rstb_o,
	output logic prbs_rstb_o
);
	import jtag_debug_pkg::*;

	dbg_reg_addr_e addr;
	logic cdr_run;
	logic prbs_run;
	logic [`DBG_DATA_WIDTH-1:0] rd_value;

	assign addr = dbg_reg_addr_e'(reg_addr_i);

	// Only defined fields are written
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cdr_run <= 1'b0;
			prbs_run <= 1'b0;
			kp_o <= 4'h2;
			ki_o <= 4'h2;
			ext_pi_ctl_o <= '0;
			en_ext_pi_ctl_o <= 1'b0;
			prbs_eqn_o <= '0;
			prbs_cke_o <= 1'b0;
		end else if (wr_en_i) begin
			case (addr)
				ADDR_CTRL: begin
					cdr_run <= wr_data_i[0];
					prbs_run <= wr_data_i[1];
				end
				ADDR_CDR_GAIN: begin
					kp_o <= wr_data_i[3:0];
					ki_o <= wr_data_i[7:4];
				end
				ADDR_PI_CTL: begin
					ext_pi_ctl_o <= wr_data_i[7:0];
					en_ext_pi_ctl_o <= wr_data_i[8];
				end
				ADDR_PRBS_CFG: begin
					prbs_eqn_o <= wr_data_i[1:0];
					prbs_cke_o <= wr_data_i[4];
				end
				// Status and unmapped addresses drop the write
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		rd_value = '0;
		case (addr)
			ADDR_CTRL: begin
				rd_value[0] = cdr_run;
				rd_value[1] = prbs_run;
			end
			ADDR_CDR_GAIN: begin
				rd_value[3:0] = kp_o;
				rd_value[7:4] = ki_o;
			end
			ADDR_PI_CTL: begin
				rd_value[7:0] = ext_pi_ctl_o;
				rd_value[8] = en_ext_pi_ctl_o;
			end
			ADDR_PRBS_CFG: begin
				rd_value[1:0] = prbs_eqn_o;
				rd_value[4] = prbs_cke_o;
			end
			ADDR_PHASE_EST:  rd_value[9:0] = phase_est_i;
			ADDR_PRBS_ERR:   rd_value = prbs_err_bits_i;
			ADDR_PRBS_TOTAL: rd_value = prbs_total_bits_i;
			default:         rd_value = '0;
		endcase
	end

	// Status is sampled only when a read is requested
	always_ff @(posedge clk) begin
		if (rd_req_i) begin
			rd_data_o <= rd_value;
		end
	end

	// Block resets combine the chip reset with the run bits
	assign cdr_rstb_o = ~reset_i & cdr_run;
	assign prbs_rstb_o = ~reset_i & prbs_run;

endmodule

`default_nettype wire

/* hdl/jtag_debug_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_debug_settings.svh"

module jtag_debug_top (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic trst_n_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	output logic tdo_o,
	input wire logic [9:0] phase_est_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] prbs_err_bits_i,
	input wire logic [`DBG_DATA_WIDTH-1:0] prbs_total_bits_i,
	output logic [3:0] kp_o,
	output logic [3:0] ki_o,
	output logic en_ext_pi_ctl_o,
	output logic [7:0] ext_pi_ctl_o,
	output logic [1:0] prbs_eqn_o,
	output logic prbs_cke_o,
	output logic cdr_rstb_o,
	output logic prbs_rstb_o
);
	import jtag_debug_pkg::*;

	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_s;
	logic capture_dr;
	logic shift_dr;
	logic update_dr;
	jtag_instr_e instr;
	logic ir_tdo;
	logic ir_shift;
	logic [`DBG_ADDR_WIDTH-1:0] reg_addr;
	logic rd_req;
	logic wr_en;
	logic [`DBG_DATA_WIDTH-1:0] wr_data;
	logic [`DBG_DATA_WIDTH-1:0] rd_data;

	// Probe pins into the clk domain
	jtag_pin_sync jtag_pin_sync_inst (
		.clk(clk),
		.reset_i(reset_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tck_rise_o(tck_rise),
		.tck_fall_o(tck_fall),
		.tms_o(tms_s),
		.tdi_o(tdi_s),
		.trst_o(trst_s)
	);

	jtag_tap_ctrl jtag_tap_ctrl_inst (
		.clk(clk),
		.reset_i(reset_i),
		.tck_rise_i(tck_rise),
		.tms_i(tms_s),
		.tdi_i(tdi_s),
		.trst_i(trst_s),
		.capture_dr_o(capture_dr),
		.shift_dr_o(shift_dr),
		.update_dr_o(update_dr),
		.instr_o(instr),
		.ir_tdo_o(ir_tdo),
		.ir_shift_o(ir_shift)
	);

	jtag_dr_chain jtag_dr_chain_inst (
		.clk(clk),
		.reset_i(reset_i),
		.tck_rise_i(tck_rise),
		.tck_fall_i(tck_fall),
		.tdi_i(tdi_s),
		.capture_dr_i(capture_dr),
		.shift_dr_i(shift_dr),
		.update_dr_i(update_dr),
		.instr_i(instr),
		.ir_tdo_i(ir_tdo),
		.ir_shift_i(ir_shift),
		.rd_data_i(rd_data),
		.reg_addr_o(reg_addr),
		.rd_req_o(rd_req),
		.wr_en_o(wr_en),
		.wr_data_o(wr_data),
		.tdo_o(tdo_o)
	);

	// Config toward the CDR loop and PRBS checker
	debug_reg_file debug_reg_file_inst (
		.clk(clk),
		.reset_i(reset_i),
		.reg_addr_i(reg_addr),
		.rd_req_i(rd_req),
		.wr_en_i(wr_en),
		.wr_data_i(wr_data),
		.rd_data_o(rd_data),
		.phase_est_i(phase_est_i),
		.prbs_err_bits_i(prbs_err_bits_i),
		.prbs_total_bits_i(prbs_total_bits_i),
		.kp_o(kp_o),
		.ki_o(ki_o),
		.en_ext_pi_ctl_o(en_ext_pi_ctl_o),
		.ext_pi_ctl_o(ext_pi_ctl_o),
		.prbs_eqn_o(prbs_eqn_o),
		.prbs_cke_o(prbs_cke_o),
		.cdr_rstb_o(cdr_rstb_o),
		.prbs_rstb_o(prbs_rstb_o)
	);

endmodule

`default_nettype wire

/* test/jtag_debug_props.sv */
`timescale 1ns/1ps

module jtag_debug_props (
	input logic clk,
	input logic reset_i,
	input logic trst_i,
	input jtag_debug_pkg::jtag_state_e state_q,
	input jtag_debug_pkg::jtag_instr_e instr_o,
	input logic capture_dr_o,
	input logic shift_dr_o,
	input logic update_dr_o,
	input logic ir_shift_o
);
	import jtag_debug_pkg::*;

	trst_to_tlr: assert property (@(posedge clk) trst_i |=> state_q == TEST_LOGIC_RESET)
		else $error("trst_i did not force TEST_LOGIC_RESET");

	tlr_idcode: assert property (@(posedge clk) disable iff (reset_i)
		state_q == TEST_LOGIC_RESET |-> instr_o == INSTR_IDCODE)
		else $error("instruction is not IDCODE in TEST_LOGIC_RESET");

	shift_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(shift_dr_o && ir_shift_o))
		else $error("DR and IR shift at once");

	// Capture, shift and update never overlap
	pulse_onehot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0({capture_dr_o, shift_dr_o, update_dr_o}))
		else $error("more than one DR pulse high");

endmodule

bind jtag_tap_ctrl jtag_debug_props jtag_debug_props_inst (
	.clk(clk), .reset_i(reset_i), .trst_i(trst_i), .state_q(state_q),
	.instr_o(instr_o), .capture_dr_o(capture_dr_o), .shift_dr_o(shift_dr_o),
	.update_dr_o(update_dr_o), .ir_shift_o(ir_shift_o)
);

/* test/jtag_debug_tb.sv */
`timescale 1ns/1ps

`include "jtag_debug_settings.svh"

module jtag_debug_tb;
	import jtag_debug_pkg::*;

	typedef enum int {OP_RW, OP_RO} op_kind_e;
	localparam int TCK_PHASE = 6;
	localparam int TIMEOUT = 200;
	localparam int NROWS = 8;

	logic clk = 1'b0;
	logic reset_i;
	logic tck;
	logic trst_n;
	logic tms;
	logic tdi;
	logic tdo;
	logic [9:0] phase_est;
	logic [31:0] prbs_err;
	logic [31:0] prbs_total;
	logic [3:0] kp;
	logic [3:0] ki;
	logic en_ext;
	logic cdr_rstb;
	logic prbs_rstb;
	logic prbs_cke;
	logic [7:0] ext_pi;
	logic [1:0] prbs_eqn;

	op_kind_e row_op[NROWS];
	logic [7:0] row_addr[NROWS];
	logic [31:0] row_data[NROWS];
	logic [31:0] row_exp[NROWS];
	string row_name[NROWS];

	jtag_debug_top jtag_debug_top_inst (
		.clk(clk), .reset_i(reset_i), .tck_i(tck), .trst_n_i(trst_n), .tms_i(tms),
		.tdi_i(tdi), .tdo_o(tdo), .phase_est_i(phase_est), .prbs_err_bits_i(prbs_err),
		.prbs_total_bits_i(prbs_total), .kp_o(kp), .ki_o(ki), .en_ext_pi_ctl_o(en_ext),
		.ext_pi_ctl_o(ext_pi), .prbs_eqn_o(prbs_eqn), .prbs_cke_o(prbs_cke),
		.cdr_rstb_o(cdr_rstb), .prbs_rstb_o(prbs_rstb)
	);

	always #10 clk = ~clk;

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input logic [`DBG_DATA_WIDTH-1:0] exp,
			input logic [`DBG_DATA_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_cfg(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "config mismatch");
		end
	endtask

	// Hold one TCK level and wait for the synchronized edge when one is due
	task automatic hold_phase(input logic rising, input logic edge_due);
		int cnt;
		logic seen;
		cnt = 0;
		seen = !edge_due;
		while (cnt < TCK_PHASE || !seen) begin
			@(posedge clk);
			cnt++;
			if (rising ? jtag_debug_top_inst.tck_rise : jtag_debug_top_inst.tck_fall)
				seen = 1'b1;
			if (cnt > TIMEOUT)
				stop_on_timeout("a synchronized TCK edge");
		end
	endtask

	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		logic fall_due;
		fall_due = (tck == 1'b1);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		hold_phase(1'b0, fall_due);
		@(negedge clk);
		tdo_v = tdo;
		@(posedge clk);
		tck <= 1'b1;
		hold_phase(1'b1, 1'b1);
	endtask

	task automatic tms_seq(input logic [7:0] bits, input int n);
		logic unused;
		for (int i = 0; i < n; i++)
			tck_cycle(bits[i], 1'b0, unused);
	endtask

	// Starts and ends in Run-Test/Idle
	task automatic scan_ir(input logic [3:0] code);
		logic unused;
		tms_seq(8'b0011, 4);
		for (int i = 0; i < 4; i++)
			tck_cycle(i == 3, code[i], unused);
		tms_seq(8'b01, 2);
	endtask

	task automatic scan_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
		dout = '0;
		tms_seq(8'b001, 3);
		for (int i = 0; i < n; i++)
			tck_cycle(i == n - 1, din[i], dout[i]);
		tms_seq(8'b01, 2);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_i <= 1'b1;
		tck <= 1'b0;
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;
		tms_seq(8'b011111, 6);
	endtask

	function automatic logic [31:0] field_mask(input logic [7:0] addr);
		case (addr)
			8'h00: return 32'h0000_0003;
			8'h01: return 32'h0000_00FF;
			8'h02: return 32'h0000_01FF;
			8'h03: return 32'h0000_0013;
			default: return 32'h0;
		endcase
	endfunction

	task automatic add_row(input int i, input op_kind_e op, input logic [7:0] a,
			input logic [31:0] ex, input string nm);
		row_op[i] = op;
		row_addr[i] = a;
		row_data[i] = $urandom;
		row_exp[i] = (op == OP_RW) ? (row_data[i] & field_mask(a)) : ex;
		row_name[i] = nm;
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] dummy;
		int cnt;
		void'($urandom(53938));
		reset_i = 1'b1;
		tck = 1'b0;
		trst_n = 1'b1;
		tms = 1'b1;
		tdi = 1'b0;
		phase_est = 10'($urandom);
		prbs_err = $urandom;
		prbs_total = $urandom;
		add_row(0, OP_RW, 8'h00, 0, "ctrl");
		add_row(1, OP_RW, 8'h01, 0, "cdr_gain");
		add_row(2, OP_RW, 8'h02, 0, "pi_ctl");
		add_row(3, OP_RW, 8'h03, 0, "prbs_cfg");
		add_row(4, OP_RO, 8'h10, {22'b0, phase_est}, "phase_est");
		add_row(5, OP_RO, 8'h11, prbs_err, "prbs_err");
		add_row(6, OP_RO, 8'h12, prbs_total, "prbs_total");
		add_row(7, OP_RO, 8'h40, 32'h0, "unmapped");

		apply_reset();
		check_cfg("cdr_rstb after reset", 8'h0, 8'(cdr_rstb));
		check_cfg("prbs_rstb after reset", 8'h0, 8'(prbs_rstb));
		scan_dr(32, 32'h0, d);
		check_data("idcode after reset", `JTAG_IDCODE, d);
		scan_ir(INSTR_BYPASS);
		tms_seq(8'b011111, 6);
		scan_dr(32, 32'h0, d);
		check_data("idcode after tms reset", `JTAG_IDCODE, d);

		scan_ir(INSTR_BYPASS);
		@(posedge clk);
		trst_n <= 1'b0;
		cnt = 0;
		while (jtag_debug_top_inst.instr !== INSTR_IDCODE) begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("TRST_N to reload IDCODE");
		end
		trst_n <= 1'b1;
		cnt = 0;
		while (jtag_debug_top_inst.trst_s !== 1'b0) begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("TRST_N release");
		end
		tms_seq(8'b0, 1);
		scan_dr(32, 32'h0, d);
		check_data("idcode after trst", `JTAG_IDCODE, d);

		// One-bit delay through bypass
		d = $urandom;
		scan_ir(INSTR_BYPASS);
		scan_dr(16, {16'h0, d[15:0]}, dummy);
		check_data("bypass", {16'h0, d[14:0], 1'b0}, dummy);
		scan_ir(4'd5);
		scan_dr(16, {16'h0, d[15:0]}, dummy);
		check_data("undefined instr", {16'h0, d[14:0], 1'b0}, dummy);

		for (int i = 0; i < NROWS; i++) begin
			scan_ir(INSTR_REG_ADDR);
			scan_dr(8, {24'h0, row_addr[i]}, dummy);
			scan_ir(INSTR_REG_DATA);
			scan_dr(32, row_data[i], dummy);
			scan_dr(32, row_data[i], d);
			check_data(row_name[i], row_exp[i], d);
			if (row_op[i] == OP_RW) begin
				case (row_addr[i])
					8'h01: begin
						check_cfg("kp_o", {4'h0, row_data[i][3:0]}, {4'h0, kp});
						check_cfg("ki_o", {4'h0, row_data[i][7:4]}, {4'h0, ki});
					end
					8'h02: begin
						check_cfg("ext_pi_ctl_o", row_data[i][7:0], ext_pi);
						check_cfg("en_ext_pi_ctl_o", 8'(row_data[i][8]), 8'(en_ext));
					end
					8'h03: begin
						check_cfg("prbs_eqn_o", 8'(row_data[i][1:0]), 8'(prbs_eqn));
						check_cfg("prbs_cke_o", 8'(row_data[i][4]), 8'(prbs_cke));
					end
					default: begin
					end
				endcase
			end
		end

		// Status and unmapped writes leave the config alone
		check_cfg("gains kept", row_data[1][7:0], {ki, kp});
		check_cfg("pi kept", row_data[2][7:0], ext_pi);
		check_cfg("run bits kept", {6'h0, row_data[0][0], row_data[0][1]},
			{6'h0, cdr_rstb, prbs_rstb});

		// Run bits and block resets
		scan_ir(INSTR_REG_ADDR);
		scan_dr(8, 32'h00, dummy);
		scan_ir(INSTR_REG_DATA);
		scan_dr(32, 32'h0, dummy);
		check_cfg("both rstb low", 8'h0, {6'h0, cdr_rstb, prbs_rstb});
		scan_dr(32, 32'h1, dummy);
		check_cfg("cdr_rstb only", 8'h2, {6'h0, cdr_rstb, prbs_rstb});
		scan_dr(32, 32'h3, dummy);
		check_cfg("both rstb high", 8'h3, {6'h0, cdr_rstb, prbs_rstb});
		@(posedge clk);
		reset_i <= 1'b1;
		@(negedge clk);
		check_cfg("rstb during reset", 8'h0, {6'h0, cdr_rstb, prbs_rstb});
		apply_reset();
		check_cfg("rstb after re-reset", 8'h0, {6'h0, cdr_rstb, prbs_rstb});
		check_cfg("gains after re-reset", 8'h22, {ki, kp});
		check_cfg("pi after re-reset", 8'h0, ext_pi | 8'(en_ext));
		check_cfg("prbs cfg after re-reset", 8'h0, 8'({prbs_cke, prbs_eqn}));

		// Address capture shows the stored address
		scan_ir(INSTR_REG_ADDR);
		scan_dr(8, 32'h5A, d);
		check_data("addr capture reset", 32'h0, d);
		scan_dr(8, 32'hC3, d);
		check_data("addr capture previous", 32'h5A, d);

		$display("Done: no errors");
		$finish;
	end

	initial begin
		#50ms;
		stop_on_timeout("the end of the run");
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/jtag_debug_pkg.sv
hdl/jtag_pin_sync.sv
hdl/jtag_tap_ctrl.sv
hdl/jtag_dr_chain.sv
hdl/debug_reg_file.sv
hdl/jtag_debug_top.sv
test/jtag_debug_props.sv
test/jtag_debug_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= jtag_debug_tb
RTL_TOP ?= jtag_debug_top
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
